//--- design/imu_spi_pkg.sv
/*
 * Shared types and constants for the sensor hub SPI host
 * Data widths, APB register map and the SPI master state encoding
 */
package imu_spi_pkg;

    typedef logic [7:0]  spi_byte_t;   // One byte on the wire
    typedef logic [2:0]  xfer_len_t;   // Bytes per transfer, 1 to 4
    typedef logic [31:0] xfer_word_t;  // Byte 0 in bits 7:0, sent first
    typedef logic [3:0]  apb_addr_t;

    localparam int MAX_XFER_BYTES = 4;

    // APB register offsets
    localparam apb_addr_t REG_CTRL   = 4'h0;
    localparam apb_addr_t REG_STATUS = 4'h4;
    localparam apb_addr_t REG_TXDATA = 4'h8;
    localparam apb_addr_t REG_RXDATA = 4'hC;

    localparam xfer_len_t HDR_BYTES = 3'd4;  // Report header length

    typedef enum logic [2:0] {
        IDLE,
        CS_SETUP,
        SHIFT,
        CS_HOLD,
        DONE
    } spi_state_t;

endpackage

//--- design/spi_link_if.sv
`timescale 1ns/10ps

/*
 * Transfer request link between a requester and the SPI side
 * Requester holds req with stable len and tx_word until done pulses
 */
interface spi_link_if;
    import imu_spi_pkg::*;

    logic       req;
    xfer_len_t  len;
    xfer_word_t tx_word;
    logic       gnt;
    xfer_word_t rx_word;   // Valid in the done cycle
    logic       done;

    modport requester (
        output req, len, tx_word,
        input  gnt, rx_word, done
    );

    modport server (
        input  req, len, tx_word,
        output gnt, rx_word, done
    );

endinterface

//--- design/imu_spi_master.sv
`timescale 1ns/10ps

/*
 * SPI mode 3 shift engine
 * Sends len bytes of tx_word under one chip select, MSB first per byte,
 * and collects MISO into rx_word. One cycle of CS setup and hold.
 */
module imu_spi_master #(
    parameter int SCK_HALF = 2
) (
    input  logic       clk,
    input  logic       rst_n,
    spi_link_if.server link,
    output logic       spi_cs_n,
    output logic       spi_sck,
    output logic       spi_mosi,
    input  logic       spi_miso
);
    import imu_spi_pkg::*;

    localparam int DIV_W   = (SCK_HALF > 1) ? $clog2(SCK_HALF) : 1;
    localparam int LOW_END = SCK_HALF / 2 - 1;  // Last cycle with sck low

    spi_state_t       state;
    logic [DIV_W-1:0] div_cnt;   // Position inside one bit period
    logic [2:0]       bit_cnt;
    logic [1:0]       byte_cnt;
    logic [2:0]       next_bit;
    logic [1:0]       next_byte;
    logic             rise_edge;
    logic             bit_end;
    logic             last_bit;
    spi_byte_t        rx_sr;
    spi_byte_t        rx_next;
    xfer_word_t       rx_word;

    assign rise_edge = (state == SHIFT) && (div_cnt == DIV_W'(LOW_END));
    assign bit_end   = (state == SHIFT) && (div_cnt == DIV_W'(SCK_HALF - 1));
    assign last_bit  = (bit_cnt == 3'd7) && ({1'b0, byte_cnt} == link.len - 3'd1);
    assign next_bit  = bit_cnt + 3'd1;
    assign next_byte = (bit_cnt == 3'd7) ? byte_cnt + 2'd1 : byte_cnt;
    assign rx_next   = {rx_sr[6:0], spi_miso};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            spi_cs_n <= 1'b1;
            spi_sck  <= 1'b1;   // CPOL=1 idle level
            spi_mosi <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (link.req) begin
                        state    <= CS_SETUP;
                        spi_cs_n <= 1'b0;
                        div_cnt  <= '0;
                        bit_cnt  <= '0;
                        byte_cnt <= '0;
                    end
                end
                CS_SETUP: begin
                    state    <= SHIFT;
                    spi_sck  <= 1'b0;            // First falling edge
                    spi_mosi <= link.tx_word[7];
                end
                SHIFT: begin
                    if (rise_edge) begin
                        spi_sck <= 1'b1;         // Sample edge for both sides
                    end
                    if (bit_end) begin
                        div_cnt <= '0;
                        if (last_bit) begin
                            state    <= CS_HOLD;
                            spi_cs_n <= 1'b1;
                        end else begin
                            spi_sck  <= 1'b0;
                            spi_mosi <= link.tx_word[{next_byte, ~next_bit}];
                            bit_cnt  <= next_bit;
                            byte_cnt <= next_byte;
                        end
                    end else begin
                        div_cnt <= div_cnt + DIV_W'(1);
                    end
                end
                CS_HOLD: state <= DONE;
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Receive path, bytes land in the same slot they were sent from
    always_ff @(posedge clk) begin
        if (state == IDLE && link.req) begin
            rx_word <= '0;   // Unused upper bytes stay zero
        end else if (rise_edge) begin
            rx_sr <= rx_next;
            if (bit_cnt == 3'd7) begin
                rx_word[{byte_cnt, 3'b000} +: 8] <= rx_next;
            end
        end
    end

    assign link.gnt     = (state != IDLE);
    assign link.done    = (state == DONE);
    assign link.rx_word = rx_word;

endmodule

//--- design/spi_link_arbiter.sv
`timescale 1ns/10ps

/*
 * Two-way arbiter for the SPI link
 * Alternates between command port and report poller, holds the grant
 * until the master signals done
 */
module spi_link_arbiter (
    input  logic          clk,
    input  logic          rst_n,
    spi_link_if.server    cmd_link,
    spi_link_if.server    poll_link,
    spi_link_if.requester master_link
);
    localparam logic OWN_CMD  = 1'b0;
    localparam logic OWN_POLL = 1'b1;

    logic busy;          // Grant outstanding
    logic owner;
    logic last_served;
    logic grant_now;
    logic pick_poll;

    // Only start when nothing is granted and the master is back in idle
    assign grant_now = !busy && !master_link.gnt && (cmd_link.req || poll_link.req);
    assign pick_poll = poll_link.req && (!cmd_link.req || last_served == OWN_CMD);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            owner       <= OWN_CMD;
            last_served <= OWN_POLL;   // Command port goes first
        end else if (grant_now) begin
            busy  <= 1'b1;
            owner <= pick_poll;
        end else if (busy && master_link.done) begin
            busy        <= 1'b0;
            last_served <= owner;
        end
    end

    assign master_link.req     = busy;
    assign master_link.len     = (owner == OWN_POLL) ? poll_link.len : cmd_link.len;
    assign master_link.tx_word = (owner == OWN_POLL) ? poll_link.tx_word : cmd_link.tx_word;

    assign cmd_link.gnt  = busy && (owner == OWN_CMD);
    assign poll_link.gnt = busy && (owner == OWN_POLL);

    assign cmd_link.done  = cmd_link.gnt && master_link.done;
    assign poll_link.done = poll_link.gnt && master_link.done;

    assign cmd_link.rx_word  = (owner == OWN_CMD) ? master_link.rx_word : '0;
    assign poll_link.rx_word = (owner == OWN_POLL) ? master_link.rx_word : '0;

endmodule

//--- design/apb_cmd_port.sv
`timescale 1ns/10ps

/*
 * APB command port for CPU driven SPI transfers
 * Holds TXDATA, launches transfers from CTRL and keeps status and RXDATA
 */
module apb_cmd_port (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  imu_spi_pkg::apb_addr_t paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    spi_link_if.requester         link
);
    import imu_spi_pkg::*;

    logic       acc;
    logic       wr;
    logic       rd;
    logic       err;
    logic       bad_len;
    logic       start_ok;
    logic       busy;
    logic       done_flag;   // Sticky until STATUS is read
    xfer_len_t  wr_len;
    xfer_len_t  pend_len;
    xfer_word_t tx_data;
    xfer_word_t rx_data;
    xfer_word_t cmd_word;    // TXDATA frozen at start

    assign acc     = psel && penable;
    assign wr      = acc && pwrite;
    assign rd      = acc && !pwrite;
    assign wr_len  = pwdata[3:1];
    assign bad_len = (wr_len == '0) || (wr_len > xfer_len_t'(MAX_XFER_BYTES));

    always_comb begin
        err    = 1'b0;
        prdata = '0;
        case (paddr)
            REG_CTRL:   err = pwrite && (bad_len || (pwdata[0] && busy));
            REG_STATUS: begin
                err    = pwrite;
                prdata = {30'd0, done_flag, busy};
            end
            REG_TXDATA: prdata = tx_data;
            REG_RXDATA: begin
                err    = pwrite;
                prdata = rx_data;
            end
            default:    err = 1'b1;   // Unmapped
        endcase
    end

    assign pready   = 1'b1;
    assign pslverr  = acc && err;
    assign start_ok = wr && !err && (paddr == REG_CTRL) && pwdata[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            done_flag <= 1'b0;
            pend_len  <= '0;
            tx_data   <= '0;
            rx_data   <= '0;
        end else begin
            if (start_ok) begin
                busy     <= 1'b1;
                pend_len <= wr_len;
            end else if (link.done) begin
                busy <= 1'b0;
            end
            if (wr && !err && (paddr == REG_TXDATA)) begin
                tx_data <= pwdata;
            end
            // A finishing transfer wins over a clearing read
            if (link.done) begin
                done_flag <= 1'b1;
                rx_data   <= link.rx_word;
            end else if (rd && (paddr == REG_STATUS)) begin
                done_flag <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            cmd_word <= tx_data;
        end
    end

    assign link.req     = busy;
    assign link.len     = pend_len;
    assign link.tx_word = cmd_word;

endmodule

//--- design/report_poller.sv
`timescale 1ns/10ps

/*
 * Report header poller
 * Reads the 4-byte header on a low int_n and presents it with a valid pulse
 */
module report_poller (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    int_n,
    spi_link_if.requester           link,
    output imu_spi_pkg::xfer_word_t hdr_data,
    output logic                    hdr_valid
);
    import imu_spi_pkg::*;

    logic [1:0] int_sync;   // Two-flop synchronizer
    logic       int_low;
    logic       armed;      // Set again only once int_n is back high
    logic       pending;

    assign int_low = !int_sync[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_sync  <= 2'b11;
            armed     <= 1'b1;
            pending   <= 1'b0;
            hdr_valid <= 1'b0;
        end else begin
            int_sync  <= {int_sync[0], int_n};
            hdr_valid <= link.done;
            if (link.done) begin
                pending <= 1'b0;
            end else if (armed && int_low && !pending) begin
                pending <= 1'b1;
                armed   <= 1'b0;
            end
            if (!int_low) begin
                armed <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (link.done) begin
            hdr_data <= link.rx_word;
        end
    end

    assign link.req     = pending;
    assign link.len     = HDR_BYTES;
    assign link.tx_word = '0;   // Header read sends zeros

endmodule

//--- design/imu_spi_top.sv
`timescale 1ns/10ps

/*
 * Sensor hub SPI host top level
 * APB command port and report poller share one mode-3 SPI master
 */
module imu_spi_top #(
    parameter int SCK_HALF = 2
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  imu_spi_pkg::apb_addr_t  paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    output logic                    spi_cs_n,
    output logic                    spi_sck,
    output logic                    spi_mosi,
    input  logic                    spi_miso,
    input  logic                    int_n,
    output imu_spi_pkg::xfer_word_t hdr_data,
    output logic                    hdr_valid
);

    spi_link_if cmd_link ();
    spi_link_if poll_link ();
    spi_link_if master_link ();

    apb_cmd_port u_apb_cmd_port (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .link    (cmd_link)
    );

    report_poller u_report_poller (
        .clk       (clk),
        .rst_n     (rst_n),
        .int_n     (int_n),
        .link      (poll_link),
        .hdr_data  (hdr_data),
        .hdr_valid (hdr_valid)
    );

    spi_link_arbiter u_spi_link_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_link    (cmd_link),
        .poll_link   (poll_link),
        .master_link (master_link)
    );

    imu_spi_master #(
        .SCK_HALF (SCK_HALF)
    ) u_imu_spi_master (
        .clk      (clk),
        .rst_n    (rst_n),
        .link     (master_link),
        .spi_cs_n (spi_cs_n),
        .spi_sck  (spi_sck),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

endmodule

//--- bench/imu_spi_assertions.sv
`timescale 1ns/10ps

/*
 * Bound checks on the SPI host
 * Grant exclusivity, sck idle level under cs_n, reset values
 */
module imu_spi_assertions (
    input logic clk,
    input logic rst_n,
    input logic cmd_gnt,
    input logic poll_gnt,
    input logic master_gnt,
    input logic spi_cs_n,
    input logic spi_sck,
    input logic xfer_done
);
    int fail_count = 0;   // Failure tally for the end of the run

    // Master busy means exactly one requester owns the link
    one_grant: assert property (@(posedge clk) disable iff (!rst_n)
                                master_gnt |-> (cmd_gnt ^ poll_gnt))
        else begin
            $error("master active without exactly one requester granted");
            fail_count++;
        end

    // With CPOL=1 sck idles high whenever the sensor is deselected
    sck_idle: assert property (@(posedge clk) disable iff (!rst_n) spi_cs_n |-> spi_sck)
        else begin
            $error("spi_sck low while spi_cs_n is high");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge clk) !rst_n |=> (rst_n || (spi_cs_n && !xfer_done)))
        else begin
            $error("spi_cs_n or done active in reset");
            fail_count++;
        end

endmodule

bind imu_spi_top imu_spi_assertions u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_gnt    (cmd_link.gnt),
    .poll_gnt   (poll_link.gnt),
    .master_gnt (master_link.gnt),
    .spi_cs_n   (spi_cs_n),
    .spi_sck    (spi_sck),
    .xfer_done  (master_link.done)
);

//--- bench/imu_spi_tb.sv
`timescale 1ns/10ps

/*
 * Testbench for the sensor hub SPI host
 * Mode-3 sensor model, APB driver, random command and poller transfers
 */
module imu_spi_tb;
    import imu_spi_pkg::*;

    localparam int  N_XFERS     = 20;
    localparam time WATCHDOG_NS = N_XFERS * (16 * 4 + 20) * 8 * 2;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        spi_cs_n;
    logic        spi_sck;
    logic        spi_mosi;
    logic        spi_miso;
    logic        int_n;
    xfer_word_t  hdr_data;
    logic        hdr_valid;

    int errors = 0;
    int test_errs = 0;
    int tests_run = 0;
    int tests_failed = 0;

    // Sensor side log with one entry per cs_n low span
    xfer_word_t log_mosi[$];
    xfer_word_t log_miso[$];
    int         log_bits[$];
    time        log_start[$];
    time        log_end[$];
    xfer_word_t cur_mosi;
    xfer_word_t cur_miso;
    int         mosi_bits;
    int         miso_bits;
    time        cur_start;
    logic       in_xfer = 1'b0;
    spi_byte_t  mosi_sr;
    spi_byte_t  miso_byte;
    logic       miso_bit_val;
    int         hdr_count = 0;
    xfer_word_t hdr_log[$];

    imu_spi_top #(
        .SCK_HALF (2)
    ) u_imu_spi_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .spi_cs_n  (spi_cs_n),
        .spi_sck   (spi_sck),
        .spi_mosi  (spi_mosi),
        .spi_miso  (spi_miso),
        .int_n     (int_n),
        .hdr_data  (hdr_data),
        .hdr_valid (hdr_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t, the run did not reach its end", $time);
        $display("SOME TESTS FAILED");
        $finish;
    end

    always @(negedge spi_cs_n) begin
        if (rst_n) begin
            in_xfer   = 1'b1;
            cur_start = $time;
            cur_mosi  = '0;
            cur_miso  = '0;
            mosi_bits = 0;
            miso_bits = 0;
        end
    end

    always @(posedge spi_cs_n) begin
        if (in_xfer) begin
            log_mosi.push_back(cur_mosi);
            log_miso.push_back(cur_miso);
            log_bits.push_back(mosi_bits);
            log_start.push_back(cur_start);
            log_end.push_back($time);
            in_xfer = 1'b0;
        end
    end

    // Sensor drives MISO after the falling edge with a fresh random byte per slot
    always @(negedge spi_sck) begin
        if (in_xfer && miso_bits < 32) begin
            if (miso_bits % 8 == 0) begin
                miso_byte = 8'($urandom);
                cur_miso[8 * (miso_bits / 8) +: 8] = miso_byte;
            end
            miso_bit_val = miso_byte[7 - miso_bits % 8];
            miso_bits    = miso_bits + 1;
            #1;
            spi_miso = miso_bit_val;
        end
    end

    always @(posedge spi_sck) begin
        if (in_xfer) begin
            mosi_sr   = {mosi_sr[6:0], spi_mosi};
            mosi_bits = mosi_bits + 1;
            if (mosi_bits % 8 == 0 && mosi_bits <= 32) begin
                cur_mosi[8 * (mosi_bits / 8 - 1) +: 8] = mosi_sr;
            end
        end
    end

    always @(negedge clk) begin
        if (hdr_valid) begin
            hdr_count = hdr_count + 1;
            hdr_log.push_back(hdr_data);
        end
    end

    function automatic xfer_word_t len_mask(input int len);
        return (len >= 4) ? 32'hffff_ffff : ((32'h1 << (8 * len)) - 32'h1);
    endfunction

    task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
        $display("ERR %0t %s expected %h actual %h", $time, name, exp, got);
        test_errs++;
    endtask

    task automatic note_failure(input string what);
        $display("%0t: %s", $time, what);
        test_errs++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: failed, %0d errors", tests_run, name, test_errs);
            tests_failed++;
            errors += test_errs;
        end
        test_errs = 0;
    endtask

    // Two-phase APB access that ends in its access phase
    task automatic apb_access(input logic wr, input apb_addr_t addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #3;
        rdata = prdata;
        err   = pslverr;
        if (pready !== 1'b1) mismatch("pready", 32'h1, pready);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input logic [31:0] data, output logic err);
        logic [31:0] unused_rd;
        apb_access(1'b1, addr, data, unused_rd, err);
    endtask

    task automatic apb_read(input apb_addr_t addr, output logic [31:0] data, output logic err);
        apb_access(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic wait_cmd_done();
        logic [31:0] st;
        logic        err;
        int          polls;
        st    = '0;
        polls = 0;
        while (!st[1] && polls < 80) begin
            apb_read(REG_STATUS, st, err);
            polls++;
        end
        if (!st[1]) note_failure("command transfer never set STATUS.done");
    endtask

    task automatic wait_header(input int h0);
        int cycles;
        cycles = 0;
        while (hdr_count <= h0 && cycles < 200) begin
            @(posedge clk);
            cycles++;
        end
        if (hdr_count <= h0) note_failure("hdr_valid never pulsed");
    endtask

    // Bytes, bit count and cs_n span of one logged transaction
    task automatic check_xfer(input int idx, input int len, input xfer_word_t exp_mosi);
        if (log_mosi[idx] !== exp_mosi) mismatch("spi_mosi bytes", exp_mosi, log_mosi[idx]);
        if (log_bits[idx] != 8 * len) mismatch("spi_sck bits", 8 * len, log_bits[idx]);
        if (log_end[idx] - log_start[idx] != (16 * len + 1) * 8) begin
            mismatch("spi_cs_n low ns", (16 * len + 1) * 8, 32'(log_end[idx] - log_start[idx]));
        end
    endtask

    task automatic check_command(input int n0, input int len, input xfer_word_t exp_mosi);
        logic [31:0] rd;
        logic        err;
        if (log_mosi.size() != n0 + 1) begin
            note_failure("expected exactly one SPI transaction for the command");
        end else begin
            check_xfer(n0, len, exp_mosi);
            apb_read(REG_RXDATA, rd, err);
            if (rd !== log_miso[n0]) mismatch("prdata(RXDATA)", log_miso[n0], rd);
        end
    endtask

    task automatic check_reset_state();
        logic [31:0] rd;
        logic        err;
        if (spi_cs_n !== 1'b1) mismatch("spi_cs_n", 32'h1, spi_cs_n);
        if (spi_sck !== 1'b1) mismatch("spi_sck", 32'h1, spi_sck);
        if (hdr_valid !== 1'b0) mismatch("hdr_valid", 32'h0, hdr_valid);
        if (pslverr !== 1'b0) mismatch("pslverr", 32'h0, pslverr);
        apb_read(REG_STATUS, rd, err);
        if (rd !== 32'h0) mismatch("prdata(STATUS)", 32'h0, rd);
    endtask

    task automatic check_registers();
        xfer_word_t  tx;
        logic [31:0] rd;
        logic        err;
        int          n0;
        tx = $urandom;
        n0 = log_mosi.size();
        apb_write(REG_TXDATA, tx, err);
        apb_read(REG_TXDATA, rd, err);
        if (rd !== tx) mismatch("prdata(TXDATA)", tx, rd);
        if (err) note_failure("pslverr on a TXDATA read");
        apb_write(4'h2, ~tx, err);
        if (!err) note_failure("no pslverr for an unmapped write");
        apb_read(4'h6, rd, err);
        if (!err) note_failure("no pslverr for an unmapped read");
        apb_write(REG_RXDATA, ~tx, err);
        if (!err) note_failure("no pslverr for a write to RXDATA");
        apb_write(REG_STATUS, 32'h3, err);
        if (!err) note_failure("no pslverr for a write to STATUS");
        apb_write(REG_CTRL, 32'h1, err);       // Length 0
        if (!err) note_failure("no pslverr for length 0");
        apb_write(REG_CTRL, 32'hB, err);       // Length 5
        if (!err) note_failure("no pslverr for length 5");
        apb_read(REG_TXDATA, rd, err);
        if (rd !== tx) mismatch("prdata(TXDATA)", tx, rd);
        apb_read(REG_RXDATA, rd, err);
        if (rd !== 32'h0) mismatch("prdata(RXDATA)", 32'h0, rd);
        apb_read(REG_STATUS, rd, err);
        if (rd !== 32'h0) mismatch("prdata(STATUS)", 32'h0, rd);
        repeat (20) @(posedge clk);
        if (log_mosi.size() != n0) note_failure("a rejected start still ran a transfer");
    endtask

    task automatic run_command(input int len);
        xfer_word_t  tx;
        logic [31:0] rd;
        logic        err;
        int          n0;
        tx = $urandom;
        n0 = log_mosi.size();
        apb_write(REG_TXDATA, tx, err);
        apb_write(REG_CTRL, (len << 1) | 1, err);
        if (err) note_failure("legal start rejected");
        wait_cmd_done();
        check_command(n0, len, tx & len_mask(len));
        apb_read(REG_STATUS, rd, err);            // done must be gone after the read
        if (rd !== 32'h0) mismatch("prdata(STATUS)", 32'h0, rd);
    endtask

    task automatic busy_start();
        xfer_word_t  tx;
        logic [31:0] rd;
        logic        err;
        int          n0;
        tx = $urandom;
        n0 = log_mosi.size();
        apb_write(REG_TXDATA, tx, err);
        apb_write(REG_CTRL, 32'h9, err);
        if (err) note_failure("legal start rejected");
        apb_write(REG_TXDATA, ~tx, err);          // Running transfer keeps its own copy
        apb_write(REG_CTRL, 32'h5, err);
        if (!err) note_failure("no pslverr for a start while busy");
        apb_read(REG_STATUS, rd, err);
        if (rd !== 32'h1) mismatch("prdata(STATUS)", 32'h1, rd);
        wait_cmd_done();
        check_command(n0, 4, tx);
    endtask

    task automatic poll_header(input bit hold_low);
        int n0;
        int h0;
        n0 = log_mosi.size();
        h0 = hdr_count;
        @(posedge clk);
        #1;
        int_n = 1'b0;
        if (hold_low) begin
            wait_header(h0);               // int_n still low after the header arrives
            repeat (20) @(posedge clk);
        end else begin
            repeat (3) @(posedge clk);
        end
        #1;
        int_n = 1'b1;
        wait_header(h0);
        repeat (80) @(posedge clk);   // Room for a stray second read
        if (hdr_count != h0 + 1) begin
            mismatch("hdr_valid pulses", h0 + 1, hdr_count);
        end else if (log_mosi.size() != n0 + 1) begin
            note_failure("expected exactly one SPI transaction per interrupt");
        end else begin
            check_xfer(n0, 4, 32'h0);
            if (hdr_log[h0] !== log_miso[n0]) mismatch("hdr_data", log_miso[n0], hdr_log[h0]);
        end
    endtask

    task automatic contention();
        xfer_word_t  tx;
        logic [31:0] rd;
        logic        err;
        int          n0;
        int          h0;
        int          c;
        int          p;
        tx = $urandom;
        apb_write(REG_TXDATA, tx, err);
        n0 = log_mosi.size();
        h0 = hdr_count;
        fork
            apb_write(REG_CTRL, 32'h5, err);      // Two bytes
            begin
                int_n = 1'b0;
                repeat (4) @(posedge clk);
                #1;
                int_n = 1'b1;
            end
        join
        wait_cmd_done();
        wait_header(h0);
        if (log_mosi.size() != n0 + 2 || hdr_count != h0 + 1) begin
            note_failure("contention did not give one command and one header read");
        end else begin
            c = (log_bits[n0] == 16) ? n0 : n0 + 1;
            p = (c == n0) ? n0 + 1 : n0;
            // cs_n stays high at least through CS_HOLD and DONE
            if (log_start[n0 + 1] < log_end[n0] + 2 * 8) begin
                note_failure("cs_n spans overlap or leave no hold gap");
            end
            check_xfer(c, 2, tx & len_mask(2));
            check_xfer(p, 4, 32'h0);
            apb_read(REG_RXDATA, rd, err);
            if (rd !== log_miso[c]) mismatch("prdata(RXDATA)", log_miso[c], rd);
            if (hdr_log[h0] !== log_miso[p]) mismatch("hdr_data", log_miso[p], hdr_log[h0]);
        end
    endtask

    initial begin : main_seq
        void'($urandom(32'h3aa2_5788));
        rst_n    = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        spi_miso = 1'b1;
        int_n    = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_reset_state();
        finish_test("reset state");
        check_registers();
        finish_test("register access");
        repeat (10) run_command(1 + $urandom % 4);
        finish_test("command transfers");
        busy_start();
        finish_test("start while busy");
        poll_header(1'b0);
        poll_header(1'b1);
        finish_test("poller reads");
        contention();
        finish_test("contention");

        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, u_imu_spi_top.u_sva.fail_count);
        if (errors == 0 && u_imu_spi_top.u_sva.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
design/imu_spi_pkg.sv
design/spi_link_if.sv
design/imu_spi_master.sv
design/spi_link_arbiter.sv
design/apb_cmd_port.sv
design/report_poller.sv
design/imu_spi_top.sv
bench/imu_spi_assertions.sv
bench/imu_spi_tb.sv

//--- Makefile
# Verilator build and run of the SPI host testbench
SIM := obj_dir/Vimu_spi_tb

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): vlog.f design/*.sv bench/*.sv
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
		--top-module imu_spi_tb -f vlog.f

run: $(SIM)
	./$(SIM) +verilator+error+limit+100 | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
